/* motion_config.svh */
`ifndef MOTION_CONFIG_SVH
`define MOTION_CONFIG_SVH

// Move buffer depth as log2, four entries by default
`define MOVE_BUFFER_BITS 2

// Width of one SPI transfer
`define WORD_BITS 64

// API version returned by the version query
`define VERSION_MAJOR 8'd0
`define VERSION_MINOR 8'd3
`define VERSION_PATCH 8'd1

`endif

/* motion_cmd_pkg.sv */
`default_nettype none

package motion_cmd_pkg;

  // Opcodes carried in the top byte of a header word
  typedef enum logic [7:0] {
    CMD_COORDINATED_STEP = 8'd1,
    CMD_MOTOR_ENABLE     = 8'd10,
    CMD_CLK_DIVISOR      = 8'd20,
    CMD_MOTORCONFIG      = 8'd30,
    CMD_API_VERSION      = 8'd254
  } cmd_opcode_e;

  // Position inside a multi-word message
  typedef enum logic [2:0] {
    // Waiting for a header word
    MSG_HEADER,
    // Coordinated move data words
    MSG_DURATION,
    MSG_INCREMENT,
    MSG_INCINC,
    // Filler word that clocks out the version reply
    MSG_VERSION
  } msg_state_e;

endpackage

`default_nettype wire

/* motion_move_pkg.sv */
`default_nettype none

package motion_move_pkg;

  // One buffered move, 193 bits
  typedef struct packed {
    logic        [63:0] duration;
    // Steps per tick, 32 fraction bits
    logic signed [63:0] increment;
    logic signed [63:0] incinc;
    logic               dir;
  } move_t;

  // Motor configuration registers, 20 bits
  typedef struct packed {
    logic       enable;
    logic [2:0] microsteps;
    logic [7:0] current;
    logic [7:0] clock_divisor;
  } motor_cfg_t;

endpackage

`default_nettype wire

/* spi_word.sv */
`timescale 1ns/1ps
`default_nettype none

`include "motion_config.svh"

module spi_word (
  input  wire                   CLK,
  input  wire                   resetn,
  input  wire                   sck,
  input  wire                   cs,
  input  wire                   copi,
  output logic                  cipo,
  input  wire  [`WORD_BITS-1:0] word_tx,
  output logic [`WORD_BITS-1:0] word_rx,
  output logic                  word_valid
);

  localparam int CNT_BITS = $clog2(`WORD_BITS);
  localparam logic [CNT_BITS-1:0] LAST_BIT = CNT_BITS'(`WORD_BITS - 1);

  // Synchronizers, third stage only for edge detection
  logic [2:0] sck_r;
  logic [2:0] cs_r;
  logic [1:0] copi_r;

  logic [CNT_BITS-1:0]   bit_cnt;
  logic [`WORD_BITS-1:0] rx_shift;
  logic [`WORD_BITS-1:0] tx_shift;

  logic sck_rise;
  logic sck_fall;
  logic cs_fall;
  logic cs_active;

  always_ff @(posedge CLK) begin
    sck_r  <= {sck_r[1:0], sck};
    cs_r   <= {cs_r[1:0], cs};
    copi_r <= {copi_r[0], copi};
  end

  assign sck_rise  = (sck_r[2:1] == 2'b01);
  assign sck_fall  = (sck_r[2:1] == 2'b10);
  assign cs_fall   = (cs_r[2:1] == 2'b10);
  assign cs_active = ~cs_r[1];

  // Bit counter restarts whenever CS is released
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_cnt    <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == LAST_BIT) begin
          word_valid <= 1'b1;
        end
      end
    end
  end

  // Sample COPI on rising SCK
  always_ff @(posedge CLK) begin
    if (cs_active && sck_rise) begin
      rx_shift <= {rx_shift[`WORD_BITS-2:0], copi_r[1]};
      if (bit_cnt == LAST_BIT) begin
        word_rx <= {rx_shift[`WORD_BITS-2:0], copi_r[1]};
      end
    end
  end

  // Reply goes out MSB first, next bit presented on falling SCK
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      tx_shift <= '0;
    end else if (cs_fall) begin
      tx_shift <= word_tx;
    end else if (cs_active && sck_fall) begin
      tx_shift <= {tx_shift[`WORD_BITS-2:0], 1'b0};
    end
  end

  assign cipo = tx_shift[`WORD_BITS-1];

endmodule

`default_nettype wire

/* command_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "motion_config.svh"

module command_decoder
  import motion_cmd_pkg::*;
  import motion_move_pkg::*;
(
  input  wire                          CLK,
  input  wire                          resetn,
  input  wire         [`WORD_BITS-1:0] word_rx,
  input  wire                          word_valid,
  output logic        [`WORD_BITS-1:0] word_tx,
  input  wire  signed [63:0]           enc_count,
  output motor_cfg_t                   cfg,
  output move_t                        move,
  output logic                         move_push
);

  msg_state_e         state;
  cmd_opcode_e        opcode;
  logic signed [63:0] enc_snapshot;

  assign opcode = cmd_opcode_e'(word_rx[`WORD_BITS-1 -: 8]);

  // Message tracking, configuration and reply
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state             <= MSG_HEADER;
      word_tx           <= '0;
      move_push         <= 1'b0;
      cfg.enable        <= 1'b0;
      cfg.microsteps    <= 3'd2;
      cfg.current       <= 8'd140;
      cfg.clock_divisor <= 8'd40;
    end else begin
      move_push <= 1'b0;
      if (word_valid) begin
        // Reply only lives for the next transfer
        word_tx <= '0;
        case (state)
          MSG_HEADER: begin
            case (opcode)
              CMD_COORDINATED_STEP: begin
                state <= MSG_DURATION;
              end
              CMD_MOTOR_ENABLE: begin
                cfg.enable <= word_rx[0];
              end
              CMD_CLK_DIVISOR: begin
                cfg.clock_divisor <= word_rx[7:0];
              end
              CMD_MOTORCONFIG: begin
                cfg.current    <= word_rx[15:8];
                cfg.microsteps <= word_rx[2:0];
              end
              CMD_API_VERSION: begin
                word_tx <= {{(`WORD_BITS-24){1'b0}},
                            `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH};
                state   <= MSG_VERSION;
              end
              default: begin
                state <= MSG_HEADER;
              end
            endcase
          end
          MSG_DURATION: begin
            state <= MSG_INCREMENT;
          end
          MSG_INCREMENT: begin
            // Encoder position taken at the header
            word_tx <= enc_snapshot;
            state   <= MSG_INCINC;
          end
          MSG_INCINC: begin
            move_push <= 1'b1;
            state     <= MSG_HEADER;
          end
          default: begin
            state <= MSG_HEADER;
          end
        endcase
      end
    end
  end

  // Pending move fields and encoder snapshot
  always_ff @(posedge CLK) begin
    if (word_valid) begin
      case (state)
        MSG_HEADER: begin
          if (opcode == CMD_COORDINATED_STEP) begin
            move.dir     <= word_rx[0];
            enc_snapshot <= enc_count;
          end
        end
        MSG_DURATION: begin
          move.duration <= word_rx;
        end
        MSG_INCREMENT: begin
          move.increment <= word_rx;
        end
        MSG_INCINC: begin
          move.incinc <= word_rx;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* move_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "motion_config.svh"

module move_queue
  import motion_move_pkg::*;
(
  input  wire        CLK,
  input  wire        resetn,
  input  wire move_t move,
  input  wire        move_push,
  output move_t      head,
  output logic       head_valid,
  input  wire        move_pop,
  output logic       buffer_ready
);

  localparam int DEPTH = 1 << `MOVE_BUFFER_BITS;

  move_t mem [DEPTH];

  // Extra MSB tells a full ring from an empty one
  logic [`MOVE_BUFFER_BITS:0] wr_ptr;
  logic [`MOVE_BUFFER_BITS:0] rd_ptr;
  logic                       full;
  logic                       empty;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[`MOVE_BUFFER_BITS] != rd_ptr[`MOVE_BUFFER_BITS]) &&
                 (wr_ptr[`MOVE_BUFFER_BITS-1:0] == rd_ptr[`MOVE_BUFFER_BITS-1:0]);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (move_push && !full) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (move_pop && !empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (move_push && !full) begin
      mem[wr_ptr[`MOVE_BUFFER_BITS-1:0]] <= move;
    end
  end

  assign head         = mem[rd_ptr[`MOVE_BUFFER_BITS-1:0]];
  assign head_valid   = ~empty;
  assign buffer_ready = ~full;

endmodule

`default_nettype wire

/* dda_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module dda_timer
  import motion_move_pkg::*;
(
  input  wire        CLK,
  input  wire        resetn,
  input  wire  [7:0] clock_divisor,
  input  wire move_t head,
  input  wire        head_valid,
  output logic       move_pop,
  output logic       step,
  output logic       dir,
  output logic       move_done
);

  logic               active;
  logic [7:0]         div_cnt;
  logic [63:0]        remaining;
  logic signed [63:0] accum;
  logic signed [63:0] incr;
  logic [32:0]        step_pending;

  logic               tick;
  logic               start;
  logic               finish;
  logic               emit;
  logic signed [63:0] accum_next;
  logic signed [31:0] whole_delta;
  logic [31:0]        carries;

  // Wait one cycle after a pop so the old head is not restarted
  assign start  = !active && head_valid && !move_pop;
  assign tick   = active && (remaining != '0) && (div_cnt == clock_divisor);
  assign finish = active && (remaining == '0) && (step_pending == '0);
  // Pulses are spaced so each one is a separate high cycle
  assign emit   = (step_pending != '0) && !step;

  // Whole steps crossed this tick, carry or borrow out of bit 31
  assign accum_next  = accum + incr;
  assign whole_delta = accum_next[63:32] - accum[63:32];
  assign carries     = (whole_delta < 0) ? -whole_delta : whole_delta;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      active       <= 1'b0;
      div_cnt      <= '0;
      remaining    <= '0;
      step_pending <= '0;
      step         <= 1'b0;
      dir          <= 1'b0;
      move_done    <= 1'b0;
      move_pop     <= 1'b0;
    end else begin
      step         <= emit;
      move_done    <= finish;
      move_pop     <= finish;
      step_pending <= step_pending + (tick ? {1'b0, carries} : 33'd0) - 33'(emit);
      if (start) begin
        active    <= 1'b1;
        div_cnt   <= '0;
        remaining <= head.duration;
        dir       <= head.dir;
      end else if (finish) begin
        active <= 1'b0;
      end else if (tick) begin
        div_cnt   <= '0;
        remaining <= remaining - 1'b1;
      end else if (active && remaining != '0) begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // Accumulator starts from zero on every move
  always_ff @(posedge CLK) begin
    if (start) begin
      accum <= '0;
      incr  <= head.increment;
    end else if (tick) begin
      accum <= accum_next;
      incr  <= incr + head.incinc;
    end
  end

endmodule

`default_nettype wire

/* quad_enc.sv */
`timescale 1ns/1ps
`default_nettype none

module quad_enc (
  input  wire                CLK,
  input  wire                resetn,
  input  wire                enc_a,
  input  wire                enc_b,
  output logic signed [63:0] count,
  output logic               fault
);

  logic [1:0] a_sync;
  logic [1:0] b_sync;
  logic [1:0] ab_now;
  logic [1:0] ab_prev;
  logic [1:0] ab_diff;
  logic       moved;
  logic       count_up;

  always_ff @(posedge CLK) begin
    a_sync <= {a_sync[0], enc_a};
    b_sync <= {b_sync[0], enc_b};
  end

  assign ab_now  = {a_sync[1], b_sync[1]};
  assign ab_diff = ab_now ^ ab_prev;

  // Exactly one pin changed
  assign moved    = ^ab_diff;
  // New A against old B, high when A leads
  assign count_up = ab_now[1] ^ ab_prev[0];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      count   <= '0;
      fault   <= 1'b0;
      ab_prev <= ab_now;  // no false edge out of reset
    end else begin
      ab_prev <= ab_now;
      if (moved) begin
        count <= count_up ? count + 64'sd1 : count - 64'sd1;
      end
      // Both pins moved at once, position is lost
      if (&ab_diff) begin
        fault <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* motion_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "motion_config.svh"

module motion_core
  import motion_move_pkg::*;
(
  input  wire        CLK,
  input  wire        resetn,
  input  wire        sck,
  input  wire        cs,
  input  wire        copi,
  output logic       cipo,
  input  wire        enc_a,
  input  wire        enc_b,
  output logic       step,
  output logic       dir,
  output logic       move_done,
  output logic       buffer_ready,
  output logic       enc_fault,
  output logic       motor_enable,
  output logic [2:0] microsteps,
  output logic [7:0] current
);

  logic [`WORD_BITS-1:0] word_tx;
  logic [`WORD_BITS-1:0] word_rx;
  logic                  word_valid;
  logic signed [63:0]    enc_count;
  motor_cfg_t            cfg;
  move_t                 new_move;
  logic                  move_push;
  move_t                 head;
  logic                  head_valid;
  logic                  move_pop;

  spi_word i_spi_word (
    .CLK(CLK), .resetn(resetn), .sck(sck), .cs(cs), .copi(copi), .cipo(cipo),
    .word_tx(word_tx), .word_rx(word_rx), .word_valid(word_valid)
  );

  command_decoder i_command_decoder (
    .CLK(CLK), .resetn(resetn), .word_rx(word_rx), .word_valid(word_valid),
    .word_tx(word_tx), .enc_count(enc_count), .cfg(cfg), .move(new_move),
    .move_push(move_push)
  );

  move_queue i_move_queue (
    .CLK(CLK), .resetn(resetn), .move(new_move), .move_push(move_push),
    .head(head), .head_valid(head_valid), .move_pop(move_pop),
    .buffer_ready(buffer_ready)
  );

  dda_timer i_dda_timer (
    .CLK(CLK), .resetn(resetn), .clock_divisor(cfg.clock_divisor), .head(head),
    .head_valid(head_valid), .move_pop(move_pop), .step(step), .dir(dir),
    .move_done(move_done)
  );

  quad_enc i_quad_enc (
    .CLK(CLK), .resetn(resetn), .enc_a(enc_a), .enc_b(enc_b),
    .count(enc_count), .fault(enc_fault)
  );

  // Power stage settings leave the core as plain pins
  assign motor_enable = cfg.enable;
  assign microsteps   = cfg.microsteps;
  assign current      = cfg.current;

endmodule

`default_nettype wire

/* tb_motion_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "motion_config.svh"

module tb_motion_core
  import motion_cmd_pkg::*;
  import motion_move_pkg::*;
();

  localparam int DEPTH         = 1 << `MOVE_BUFFER_BITS;
  localparam int HALF_SCK      = 8;
  localparam int WORD_CYCLES   = `WORD_BITS * 2 * HALF_SCK + 4 * HALF_SCK;
  localparam int CONFIG_WORDS  = 12;
  localparam int SHORT_MOVES   = 8;
  localparam int SHORT_DUR_MAX = 40;
  // Long enough to outlast five messages at the largest divisor
  localparam int LONG_DUR_MIN  = 100;
  localparam int LONG_DUR_SPAN = 64;
  localparam int MSG_WORDS     = 2 + CONFIG_WORDS + 2 + 4 * (1 + SHORT_MOVES + DEPTH + 1);
  localparam int MAX_CYCLES    = MSG_WORDS * WORD_CYCLES
                               + (1 + SHORT_MOVES) * SHORT_DUR_MAX * 4 * 4
                               + (DEPTH + 1) * (LONG_DUR_MIN + LONG_DUR_SPAN) * 256
                               + 20000;

  // Expected outcome of one accepted move
  typedef struct packed {
    logic [31:0] steps;
    logic [31:0] min_cycles;
    logic        dir;
  } exp_move_t;

  logic       CLK;
  logic       resetn;
  logic       sck;
  logic       cs;
  logic       copi;
  logic       enc_a;
  logic       enc_b;
  logic       cipo;
  logic       step;
  logic       dir;
  logic       move_done;
  logic       buffer_ready;
  logic       enc_fault;
  logic       motor_enable;
  logic [2:0] microsteps;
  logic [7:0] current;

  motor_cfg_t         cfg_model;
  longint signed      enc_model;
  int                 phase;
  logic [31:0]        rng_state;
  exp_move_t          exp_q[$];
  int                 step_cnt = 0;
  int                 move_cycles = 0;
  int                 done_cnt = 0;
  int                 accepted_cnt = 0;
  int                 value_errors = 0;
  int                 other_errors = 0;
  int                 cycle_cnt = 0;

  motion_core i_motion_core (
    .CLK(CLK), .resetn(resetn), .sck(sck), .cs(cs), .copi(copi), .cipo(cipo),
    .enc_a(enc_a), .enc_b(enc_b), .step(step), .dir(dir), .move_done(move_done),
    .buffer_ready(buffer_ready), .enc_fault(enc_fault), .motor_enable(motor_enable),
    .microsteps(microsteps), .current(current)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [63:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = rand32();
    lo = rand32();
    return {hi, lo};
  endfunction

  // Quadrature phases with A leading
  function automatic logic [1:0] gray_ab(input int p);
    case (p)
      0: return 2'b00;
      1: return 2'b10;
      2: return 2'b11;
      default: return 2'b01;
    endcase
  endfunction

  // Carry count of a forward-only move is the final integer part
  function automatic logic [31:0] count_steps(input move_t m);
    longint signed   acc;
    longint signed   inc;
    longint unsigned t;
    acc = 0;
    inc = m.increment;
    for (t = 0; t < m.duration; t++) begin
      acc = acc + inc;
      inc = inc + m.incinc;
    end
    return 32'(acc >>> 32);
  endfunction

  function automatic move_t random_move(input int dur_min, input int dur_span);
    move_t       m;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    r1 = rand32();
    r2 = rand32();
    r3 = rand32();
    m.duration  = 64'(dur_min) + 64'(rand32() % dur_span);
    // Up to two steps per tick and slowly growing
    m.increment = {31'd0, r1[0], r2};
    m.incinc    = {36'd0, r3[27:0]};
    m.dir       = r1[1];
    return m;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge CLK);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("Error: %s", what);
      other_errors++;
    end
  endtask

  task automatic check_config();
    check_value("motor_enable", motor_enable, cfg_model.enable);
    check_value("microsteps", microsteps, cfg_model.microsteps);
    check_value("current", current, cfg_model.current);
  endtask

  // SPI mode 0 host sending one 64-bit word per CS frame
  task automatic transfer_word(input logic [63:0] tx, output logic [63:0] rx);
    int i;
    @(posedge CLK);
    cs <= 1'b0;
    for (i = `WORD_BITS - 1; i >= 0; i--) begin
      copi <= tx[i];
      wait_cycles(HALF_SCK);
      sck   <= 1'b1;
      rx[i] = cipo;
      wait_cycles(HALF_SCK);
      sck <= 1'b0;
    end
    wait_cycles(HALF_SCK);
    cs   <= 1'b1;
    copi <= 1'b0;
    wait_cycles(HALF_SCK);
  endtask

  task automatic set_divisor(input logic [7:0] d);
    logic [63:0] rx;
    transfer_word({CMD_CLK_DIVISOR, 48'd0, d}, rx);
    cfg_model.clock_divisor = d;
  endtask

  task automatic encoder_step(input logic up);
    logic [1:0] ab;
    phase = up ? (phase + 1) % 4 : (phase + 3) % 4;
    ab    = gray_ab(phase);
    @(posedge CLK);
    enc_a <= ab[1];
    enc_b <= ab[0];
    enc_model = up ? enc_model + 1 : enc_model - 1;
    wait_cycles(6 + int'(rand32() % 4));
  endtask

  // Both pins flip together and the count must hold
  task automatic encoder_glitch();
    logic [1:0] ab;
    phase = (phase + 2) % 4;
    ab    = gray_ab(phase);
    @(posedge CLK);
    enc_a <= ab[1];
    enc_b <= ab[0];
    wait_cycles(6);
  endtask

  task automatic send_move(input move_t m, input logic accepted);
    logic [63:0] rx;
    logic [63:0] w;
    logic [63:0] snapshot;
    exp_move_t   e;
    snapshot = enc_model;
    w        = rand_word();
    transfer_word({CMD_COORDINATED_STEP, w[55:1], m.dir}, rx);
    check_value("cipo_header_reply", rx, '0);
    transfer_word(m.duration, rx);
    check_value("cipo_duration_reply", rx, '0);
    transfer_word(m.increment, rx);
    check_value("cipo_increment_reply", rx, '0);
    // Queued before the move can start stepping
    if (accepted) begin
      e.steps      = count_steps(m);
      e.min_cycles = 32'(m.duration) * (32'(cfg_model.clock_divisor) + 32'd1);
      e.dir        = m.dir;
      exp_q.push_back(e);
      accepted_cnt++;
    end
    transfer_word(m.incinc, rx);
    check_value("cipo_snapshot", rx, snapshot);
  endtask

  task automatic wait_moves_done();
    while (done_cnt != accepted_cnt) begin
      @(posedge CLK);
    end
  endtask

  // Step and move_done monitor against the expected move list
  always @(posedge CLK) begin
    if (resetn) begin
      move_cycles++;
      if (step) begin
        step_cnt++;
        if (exp_q.size() == 0) begin
          check_true(1'b0, "step pulse while no move was pending");
        end else begin
          check_value("dir", dir, exp_q[0].dir);
        end
      end
      if (move_done) begin
        if (exp_q.size() == 0) begin
          check_true(1'b0, "move_done pulsed while no move was pending");
        end else begin
          check_value("step_count", step_cnt, exp_q[0].steps);
          check_true(move_cycles >= exp_q[0].min_cycles,
                     "move finished before its ticks could have elapsed");
          void'(exp_q.pop_front());
        end
        step_cnt    = 0;
        move_cycles = 0;
        done_cnt <= done_cnt + 1;
      end
    end
  end

  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    logic [63:0] rx;
    logic [63:0] w;
    logic [31:0] r;
    logic [7:0]  op;
    int          i;
    int          pushes;
    int          drained;
    resetn = 1'b0;
    sck    = 1'b0;
    cs     = 1'b1;
    copi   = 1'b0;
    enc_a  = 1'b0;
    enc_b  = 1'b0;
    rng_state = 32'h55cf_1d2d;
    cfg_model.enable        = 1'b0;
    cfg_model.microsteps    = 3'd2;
    cfg_model.current       = 8'd140;
    cfg_model.clock_divisor = 8'd40;
    enc_model = 0;
    phase     = 0;
    repeat (16) @(posedge CLK);
    resetn <= 1'b1;
    wait_cycles(2);
    check_value("step", step, 1'b0);
    check_value("move_done", move_done, 1'b0);
    check_value("buffer_ready", buffer_ready, 1'b1);
    check_value("enc_fault", enc_fault, 1'b0);
    check_value("cipo", cipo, 1'b0);
    check_config();

    // Version query with a move opcode in the ignored filler
    w = rand_word();
    transfer_word({CMD_API_VERSION, w[55:0]}, rx);
    check_value("cipo_reply", rx, '0);
    w = rand_word();
    transfer_word({CMD_COORDINATED_STEP, w[55:0]}, rx);
    check_value("cipo_version", rx,
                {40'd0, `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH});
    check_config();

    // Random configuration words mixed with unknown opcodes
    for (i = 0; i < CONFIG_WORDS; i++) begin
      w = rand_word();
      r = rand32();
      case (r % 4)
        0: begin
          op = CMD_MOTOR_ENABLE;
          cfg_model.enable = w[0];
        end
        1: begin
          op = CMD_MOTORCONFIG;
          cfg_model.current    = w[15:8];
          cfg_model.microsteps = w[2:0];
        end
        2: begin
          op = CMD_CLK_DIVISOR;
          cfg_model.clock_divisor = w[7:0];
        end
        default: begin
          op = {5'b10100, w[58:56]};
        end
      endcase
      transfer_word({op, w[55:0]}, rx);
      check_value("cipo_reply", rx, '0);
      check_config();
    end
    set_divisor(8'd3);

    // Encoder walk and snapshot through a move message
    for (i = 0; i < 20; i++) begin
      r = rand32();
      encoder_step(r[0]);
    end
    send_move(random_move(1, SHORT_DUR_MAX), 1'b1);
    encoder_glitch();
    check_value("enc_fault", enc_fault, 1'b1);

    // Short moves at a fast tick
    for (i = 0; i < SHORT_MOVES; i++) begin
      while (!buffer_ready) begin
        @(posedge CLK);
      end
      send_move(random_move(1, SHORT_DUR_MAX), 1'b1);
    end
    wait_moves_done();

    // Fill the queue with slow moves and drop one more
    set_divisor(8'd255);
    pushes = 0;
    while (buffer_ready && pushes < 2 * DEPTH) begin
      send_move(random_move(LONG_DUR_MIN, LONG_DUR_SPAN), 1'b1);
      pushes++;
    end
    check_value("pushes_until_full", pushes, DEPTH);
    check_value("buffer_ready", buffer_ready, 1'b0);
    send_move(random_move(LONG_DUR_MIN, LONG_DUR_SPAN), 1'b0);
    drained = done_cnt;
    while (done_cnt == drained) begin
      @(posedge CLK);
    end
    wait_cycles(2);
    check_value("buffer_ready", buffer_ready, 1'b1);
    wait_moves_done();
    wait_cycles(20);
    check_value("enc_fault", enc_fault, 1'b1);
    check_true(exp_q.size() == 0, "expected moves were never completed");

    $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* motion_core.f */
+incdir+.
motion_cmd_pkg.sv
motion_move_pkg.sv
spi_word.sv
command_decoder.sv
move_queue.sv
dda_timer.sv
quad_enc.sv
motion_core.sv
tb_motion_core.sv

/* Bender.yml */
package:
  name: motion_core

sources:
  - include_dirs:
      - .
    files:
      - motion_cmd_pkg.sv
      - motion_move_pkg.sv
      - spi_word.sv
      - command_decoder.sv
      - move_queue.sv
      - dda_timer.sv
      - quad_enc.sv
      - motion_core.sv
      - target: test
        files:
          - tb_motion_core.sv
